// ==== Bender.yml ====
package:
  name: periph

sources:
  - periph_pkg.sv
  - periph_regs.sv
  - tx_fifo.sv
  - uart_tx.sv
  - button_sync.sv
  - periph_top.sv
  - target: simulation
    files:
      - periph_chk.sv
      - periph_tb.sv

// ==== button_sync.sv ====
`timescale 1ns/100ps

module button_sync (
    input  logic clk,
    input  logic reset,
    input  logic button_i,
    output logic press_o
);

    import periph_pkg::*;

    logic                                 sync1_q;   // Metastability stage
    logic                                 sync2_q;
    logic                                 level_q;   // Accepted level
    logic                                 level_d_q; // For edge detect
    logic [$clog2(DEBOUNCE_CYCLES)-1:0]   stable_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync1_q    <= 1'b0;
            sync2_q    <= 1'b0;
            level_q    <= 1'b0;
            level_d_q  <= 1'b0;
            stable_cnt <= '0;
        end else begin
            sync1_q   <= button_i;
            sync2_q   <= sync1_q;
            level_d_q <= level_q;
            if (sync2_q == level_q) begin
                stable_cnt <= '0;                 // Bounce restarts the wait
            end else if (stable_cnt == ($clog2(DEBOUNCE_CYCLES))'(DEBOUNCE_CYCLES - 1)) begin
                level_q    <= sync2_q;            // Held long enough
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // One cycle on rising accepted level
    assign press_o = level_q & ~level_d_q;

endmodule

// ==== periph.f ====
periph_pkg.sv
periph_regs.sv
tx_fifo.sv
uart_tx.sv
button_sync.sv
periph_top.sv
periph_chk.sv
periph_tb.sv

// ==== periph_chk.sv ====
`timescale 1ns/100ps

module periph_chk (
    input logic                 clk,
    input logic                 reset,
    input periph_pkg::apb_req_t apb_req_i,
    input periph_pkg::apb_rsp_t apb_rsp_o,
    input logic                 tx_o,
    input periph_pkg::irq_vec_t irq_o
);

    import periph_pkg::*;

    int fail_count = 0;     // Assertion failures so far

    // Error flag only with a completing access
    assert property (@(posedge clk) disable iff (reset)
        apb_rsp_o.pslverr |-> apb_req_i.psel && apb_req_i.penable && apb_rsp_o.pready)
    else begin
        fail_count++;
        $error("pslverr high outside a completing access");
    end

    // Idle line during reset
    assert property (@(negedge clk) reset |-> tx_o)
    else begin
        fail_count++;
        $error("tx_o low while reset is high");
    end

    assert property (@(posedge clk) $fell(reset) |-> irq_o == irq_vec_t'('0))
    else begin
        fail_count++;
        $error("irq_o not clear right after reset");
    end

endmodule

// ==== periph_pkg.sv ====
package periph_pkg;

    //////////////////////////////
    // Bus types
    //////////////////////////////

    // Master side of the APB port
    typedef struct packed {
        logic       psel;     // Slave selected
        logic       penable;  // Access phase
        logic       pwrite;   // Write when high
        logic [7:0] paddr;    // Byte offset into the map
        logic [31:0] pwdata;  // Write data
    } apb_req_t;

    // Slave side of the APB port
    typedef struct packed {
        logic [31:0] prdata;  // Valid in the completing cycle
        logic        pready;  // Low inserts a wait state
        logic        pslverr; // Unmapped offset
    } apb_rsp_t;

    // One transmit character
    typedef logic [7:0] tx_byte_t;

    // Pending interrupt flags
    // Timer sits in bit 0, button in bit 1
    typedef struct packed {
        logic button;
        logic timer;
    } irq_vec_t;

    //////////////////////////////
    // Register map
    //////////////////////////////

    localparam logic [7:0] ADDR_TX_DATA = 8'h00; // Write pushes low byte
    localparam logic [7:0] ADDR_GPIO    = 8'h04; // Output byte
    localparam logic [7:0] ADDR_TIMER   = 8'h08; // Counter, read only
    localparam logic [7:0] ADDR_IRQ     = 8'h0C; // Flags, write one to clear
    localparam logic [7:0] ADDR_STATUS  = 8'h10; // FIFO empty and full

    //////////////////////////////
    // Sizes and timing
    //////////////////////////////

    // Transmit buffer
    localparam int unsigned FIFO_DEPTH = 8;
    localparam int unsigned FIFO_PTR_W = 3;   // log2 of depth

    // Serial line
    localparam int unsigned CLKS_PER_BIT = 8;

    // Button must hold this long after sync
    localparam int unsigned DEBOUNCE_CYCLES = 16;

    // Timer interrupt count
    localparam int unsigned TIMER_LIMIT = 500;

endpackage

// ==== periph_regs.sv ====
`timescale 1ns/100ps

module periph_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  periph_pkg::apb_req_t  apb_req_i,
    output periph_pkg::apb_rsp_t  apb_rsp_o,
    input  logic                  press_i,
    input  logic                  fifo_full_i,
    input  logic                  fifo_empty_i,
    output logic                  push_o,
    output periph_pkg::tx_byte_t  push_data_o,
    output logic [7:0]            gpio_o,
    output periph_pkg::irq_vec_t  irq_o
);

    import periph_pkg::*;

    logic        access;      // Setup done, in access phase
    logic        tx_stall;    // TX write against a full FIFO
    logic        complete;    // Transfer ends at this edge
    logic        wr_done;     // Completing write
    logic        addr_ok;     // Offset is mapped
    logic [31:0] rd_word;
    logic [7:0]  gpio_q;
    logic [31:0] timer_q;
    logic        timer_hit;
    logic        timer_clr;
    logic        button_clr;
    irq_vec_t    irq_q;

    //////////////////////////////
    // APB handshake
    //////////////////////////////

    assign access   = apb_req_i.psel & apb_req_i.penable;
    assign tx_stall = access & apb_req_i.pwrite & fifo_full_i
                    & (apb_req_i.paddr == ADDR_TX_DATA);
    assign complete = access & ~tx_stall;
    assign wr_done  = complete & apb_req_i.pwrite;

    // Address decode and read mux
    always_comb begin
        addr_ok = 1'b1;
        rd_word = '0;
        case (apb_req_i.paddr)
            ADDR_TX_DATA: rd_word = '0;                        // Write only
            ADDR_GPIO:    rd_word = {24'd0, gpio_q};
            ADDR_TIMER:   rd_word = timer_q;
            ADDR_IRQ:     rd_word = {30'd0, irq_q};
            ADDR_STATUS:  rd_word = {30'd0, fifo_full_i, fifo_empty_i};
            default: begin
                addr_ok = 1'b0;                                 // Unmapped
                rd_word = '0;
            end
        endcase
    end

    assign apb_rsp_o.prdata  = rd_word;
    assign apb_rsp_o.pready  = ~tx_stall;                       // Wait while full
    assign apb_rsp_o.pslverr = complete & ~addr_ok;

    //////////////////////////////
    // TX push
    //////////////////////////////

    // FIFO captures on the completing edge
    assign push_o      = wr_done & (apb_req_i.paddr == ADDR_TX_DATA);
    assign push_data_o = apb_req_i.pwdata[7:0];

    //////////////////////////////
    // GPIO
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio_q <= '0;
        end else if (wr_done && apb_req_i.paddr == ADDR_GPIO) begin
            gpio_q <= apb_req_i.pwdata[7:0];
        end
    end

    assign gpio_o = gpio_q;

    //////////////////////////////
    // Timer and interrupts
    //////////////////////////////

    // Write one to clear
    assign timer_clr  = wr_done & (apb_req_i.paddr == ADDR_IRQ) & apb_req_i.pwdata[0];
    assign button_clr = wr_done & (apb_req_i.paddr == ADDR_IRQ) & apb_req_i.pwdata[1];

    assign timer_hit = (timer_q == 32'(TIMER_LIMIT));

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_q <= '0;
        end else if (timer_clr) begin
            timer_q <= '0;                      // Restart with the flag
        end else begin
            timer_q <= timer_q + 32'd1;         // Free running
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            irq_q <= '0;
        end else begin
            if (timer_clr) irq_q.timer <= 1'b0;
            if (timer_hit) irq_q.timer <= 1'b1;   // Set beats clear
            if (button_clr) irq_q.button <= 1'b0;
            if (press_i) irq_q.button <= 1'b1;
        end
    end

    assign irq_o = irq_q;

endmodule

// ==== periph_tb.sv ====
`timescale 1ns/100ps

module periph_tb;

    import periph_pkg::*;

    localparam int TX_BYTES    = 24;
    localparam int CYCLE_LIMIT = 2 * (TX_BYTES * 10 * CLKS_PER_BIT + 3000);

    logic        clk = 1'b0;
    logic        reset;
    apb_req_t    apb_req_i;
    apb_rsp_t    apb_rsp_o;
    logic        button_i;
    logic [7:0]  gpio_o;
    logic        tx_o;
    irq_vec_t    irq_o;

    logic [31:0] rng = 32'h1abe;      // Xorshift state
    int          errors = 0;
    int          cycles = 0;
    int          stall_cycles = 0;    // Wait states seen by the master
    int          waited;
    tx_byte_t    exp_q[$];            // Written to TX_DATA
    tx_byte_t    rx_q[$];             // Decoded from the line
    logic [7:0]  mdl_gpio = '0;
    logic [31:0] mdl_timer;
    logic        mdl_timer_flag;
    logic        mdl_button_flag = 1'b0;
    logic [31:0] timer_at_sample;     // Model count when prdata was taken
    logic        timer_clr_req;
    logic [31:0] rd;
    logic        err;

    periph_top dut_i (.*);
    bind periph_top periph_chk chk_i (.*);

    always #4 clk = ~clk;             // 8 ns period

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout, run still going after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Timer clear completes in its first access cycle
    assign timer_clr_req = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite
                         & (apb_req_i.paddr == ADDR_IRQ) & apb_req_i.pwdata[0];

    always @(posedge clk) begin
        if (reset) begin
            mdl_timer      <= '0;
            mdl_timer_flag <= 1'b0;
        end else begin
            mdl_timer <= timer_clr_req ? 32'd0 : mdl_timer + 32'd1;
            if (mdl_timer == TIMER_LIMIT) mdl_timer_flag <= 1'b1;   // Set wins
            else if (timer_clr_req) mdl_timer_flag <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (!reset) check_bit("irq_o.timer", mdl_timer_flag, irq_o.timer);
    end

    // Line decoder sampling mid bit
    always begin : line_monitor
        tx_byte_t rx_byte;
        @(negedge tx_o);
        if (!reset) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rx_byte[i] = tx_o;                  // LSB first
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (tx_o !== 1'b1) begin
                errors++;
                $display("Stop bit missing on tx_o at %0t", $time);
            end
            rx_q.push_back(rx_byte);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic irq_vec_t expected_irq();
        irq_vec_t v;
        v.button = mdl_button_flag;
        v.timer  = mdl_timer_flag;
        return v;
    endfunction

    //////////////////////////////
    // Bus tasks
    //////////////////////////////

    task automatic bus_transfer(input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic slverr);
        @(negedge clk);
        apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(negedge clk);
        apb_req_i.penable = 1'b1;
        #1;
        while (!apb_rsp_o.pready) begin             // Any number of wait states
            stall_cycles++;
            @(negedge clk);
            #1;
        end
        rdata           = apb_rsp_o.prdata;
        slverr          = apb_rsp_o.pslverr;
        timer_at_sample = mdl_timer;
        @(negedge clk);                             // Completing edge is past
        apb_req_i = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic slverr);
        logic [31:0] unused;
        bus_transfer(1'b1, addr, data, unused, slverr);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic slverr);
        bus_transfer(1'b0, addr, 32'd0, data, slverr);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input tx_byte_t exp, input tx_byte_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_irq(input string name, input irq_vec_t exp, input irq_vec_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        reset     = 1'b1;
        apb_req_i = '0;
        button_i  = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_irq("irq_o", '0, irq_o);
        check_byte("gpio_o", '0, gpio_o);
        check_bit("tx_o", 1'b1, tx_o);
        apb_read(ADDR_STATUS, rd, err);
        check_word("prdata status", 32'h1, rd);     // Empty and not full

        repeat (20) begin
            rng = xorshift(rng);
            apb_write(ADDR_GPIO, rng, err);
            mdl_gpio = rng[7:0];
            check_byte("gpio_o", mdl_gpio, gpio_o);
            apb_read(ADDR_GPIO, rd, err);
            check_word("prdata gpio", {24'd0, mdl_gpio}, rd);
        end
        check_bit("pslverr", 1'b0, err);

        // Overfill the FIFO so later writes stall
        repeat (TX_BYTES) begin
            rng = xorshift(rng);
            apb_write(ADDR_TX_DATA, rng, err);
            exp_q.push_back(rng[7:0]);
        end
        if (stall_cycles == 0) begin
            errors++;
            $display("No wait states seen while overfilling the FIFO");
        end
        apb_read(ADDR_STATUS, rd, err);
        check_word("prdata status", 32'h2, rd);     // Refilled by the last push
        while (rx_q.size() < TX_BYTES) @(negedge clk);
        repeat (10 * CLKS_PER_BIT) @(negedge clk);  // Room for a stray extra frame
        apb_read(ADDR_STATUS, rd, err);
        check_word("prdata status", 32'h1, rd);
        check_word("frame count", TX_BYTES, rx_q.size());
        while (exp_q.size() > 0 && rx_q.size() > 0)
            check_byte("tx_o frame", exp_q.pop_front(), rx_q.pop_front());

        // Timer from a fresh clear
        apb_write(ADDR_IRQ, 32'h1, err);
        repeat (8) begin
            rng = xorshift(rng);
            repeat (rng[4:0]) @(negedge clk);
            apb_read(ADDR_TIMER, rd, err);
            check_word("prdata timer", timer_at_sample, rd);
        end
        while (!irq_o.timer) @(negedge clk);
        check_word("timer at flag", TIMER_LIMIT + 1, mdl_timer);
        apb_read(ADDR_IRQ, rd, err);
        check_irq("prdata irq", expected_irq(), irq_vec_t'(rd[1:0]));
        apb_write(ADDR_IRQ, 32'h1, err);
        check_bit("irq_o.timer", 1'b0, irq_o.timer);
        apb_read(ADDR_TIMER, rd, err);
        check_word("prdata timer", timer_at_sample, rd);

        // Bounces shorter than the debounce window
        repeat (12) begin
            rng = xorshift(rng);
            button_i = 1'b1;
            repeat (1 + rng[2:0]) @(negedge clk);
            button_i = 1'b0;
            repeat (1 + rng[5:3]) @(negedge clk);
        end
        repeat (DEBOUNCE_CYCLES + 4) @(negedge clk);
        check_bit("irq_o.button", 1'b0, irq_o.button);
        button_i = 1'b1;
        waited   = 0;
        while (!irq_o.button) begin
            @(negedge clk);
            waited++;
        end
        check_bit("button hold long enough", 1'b1, waited >= DEBOUNCE_CYCLES);
        mdl_button_flag = 1'b1;
        apb_read(ADDR_IRQ, rd, err);
        check_irq("prdata irq", expected_irq(), irq_vec_t'(rd[1:0]));
        apb_write(ADDR_IRQ, 32'h2, err);
        mdl_button_flag = 1'b0;
        check_irq("irq_o", expected_irq(), irq_o);
        button_i = 1'b0;

        // Unmapped offsets
        rng = xorshift(rng);
        apb_write(8'h14, rng, err);
        check_bit("pslverr", 1'b1, err);
        apb_read(8'h40, rd, err);
        check_bit("pslverr", 1'b1, err);
        check_byte("gpio_o", mdl_gpio, gpio_o);
        check_irq("irq_o", expected_irq(), irq_o);
        repeat (10 * CLKS_PER_BIT) @(negedge clk);
        check_word("frames after bad write", 0, rx_q.size());

        $display("Errors: %0d checks, %0d assertions", errors, dut_i.chk_i.fail_count);
        if (errors + dut_i.chk_i.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== periph_top.sv ====
`timescale 1ns/100ps

module periph_top (
    input  logic                 clk,
    input  logic                 reset,
    input  periph_pkg::apb_req_t apb_req_i,
    output periph_pkg::apb_rsp_t apb_rsp_o,
    input  logic                 button_i,
    output logic [7:0]           gpio_o,
    output logic                 tx_o,
    output periph_pkg::irq_vec_t irq_o
);

    import periph_pkg::*;

    logic     press;        // Debounced button edge
    logic     push;
    tx_byte_t push_data;
    logic     pop;
    tx_byte_t pop_data;
    logic     fifo_full;
    logic     fifo_empty;

    //////////////////////////////
    // Producer
    //////////////////////////////

    periph_regs regs_i (
        .clk          (clk),
        .reset        (reset),
        .apb_req_i    (apb_req_i),
        .apb_rsp_o    (apb_rsp_o),
        .press_i      (press),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .push_o       (push),
        .push_data_o  (push_data),
        .gpio_o       (gpio_o),
        .irq_o        (irq_o)
    );

    // Buffer
    tx_fifo fifo_i (
        .clk         (clk),
        .reset       (reset),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    // Consumer
    uart_tx uart_i (
        .clk     (clk),
        .reset   (reset),
        .empty_i (fifo_empty),
        .data_i  (pop_data),
        .pop_o   (pop),
        .tx_o    (tx_o)
    );

    button_sync button_i_sync (
        .clk      (clk),
        .reset    (reset),
        .button_i (button_i),
        .press_o  (press)
    );

endmodule

// ==== tx_fifo.sv ====
`timescale 1ns/100ps

module tx_fifo (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push_i,
    input  periph_pkg::tx_byte_t push_data_i,
    input  logic                 pop_i,
    output periph_pkg::tx_byte_t pop_data_o,
    output logic                 full_o,
    output logic                 empty_o
);

    import periph_pkg::*;

    tx_byte_t              mem [FIFO_DEPTH];    // Storage, no reset
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;               // One extra bit for full

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    assign pop_data_o = mem[rd_ptr];            // Head, valid when not empty

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    // Pointers wrap naturally at power of two depth
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1;
            if (pop_i) rd_ptr <= rd_ptr + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    assign empty_o = (count == '0);
    assign full_o  = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 empty_i,
    input  periph_pkg::tx_byte_t data_i,
    output logic                 pop_o,
    output logic                 tx_o
);

    import periph_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_t;

    state_t                            state;
    logic [$clog2(CLKS_PER_BIT)-1:0]   baud_cnt;   // Cycle within a bit
    logic                              baud_last;
    logic [2:0]                        bit_idx;    // Data bit number
    tx_byte_t                          shift_q;
    logic                              frame_end;

    assign baud_last = (baud_cnt == ($clog2(CLKS_PER_BIT))'(CLKS_PER_BIT - 1));
    assign frame_end = (state == S_STOP) & baud_last;

    // Pop when idle or in the last stop cycle
    assign pop_o = ~empty_i & ((state == S_IDLE) | frame_end);

    //////////////////////////////
    // Frame sequencer
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else if (pop_o) begin
            state    <= S_START;                  // Back to back frames
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else if (state != S_IDLE) begin
            baud_cnt <= baud_last ? '0 : baud_cnt + 1'b1;
            if (baud_last) begin
                case (state)
                    S_START: state <= S_DATA;
                    S_DATA: begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= S_STOP;
                    end
                    default: state <= S_IDLE;     // Stop bit done, FIFO empty
                endcase
            end
        end
    end

    // Shift register, LSB first
    always_ff @(posedge clk) begin
        if (pop_o) begin
            shift_q <= data_i;
        end else if (state == S_DATA && baud_last) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    // Line level from state
    assign tx_o = (state == S_START) ? 1'b0 :
                  (state == S_DATA)  ? shift_q[0] : 1'b1;

endmodule
